//--- project.f
src/typepkg.sv
src/idec.sv
src/insAssemble.sv
src/branchTarget.sv
src/predecodeTop.sv
dv/predecodeTb.sv

//--- build.sh
#!/bin/sh
# compile and run the predecoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module predecodeTb -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

//--- dv/predecodeTb.sv
`timescale 1ns/100ps

module predecodeTb;

	logic clk;
	logic rstN;
	logic byteValid;
	typepkg::dataLogic byteData;
	logic restart;
	logic [15:0] restartPc;
	logic insValid;
	typepkg::Opcode opcode;
	typepkg::Addressing mode;
	logic [1:0] length;
	logic [15:0] operand;
	logic [15:0] insPc;
	logic [15:0] target;
	logic targetValid;

	logic [61:0] gotQ[$]; // {opcode, mode, length, operand, insPc, target, targetValid}
	logic [31:0] rngState = 32'he2f89b06;

	predecodeTop uut (
		.clk(clk),
		.rstN(rstN),
		.byteValid(byteValid),
		.byteData(byteData),
		.restart(restart),
		.restartPc(restartPc),
		.insValid(insValid),
		.opcode(opcode),
		.mode(mode),
		.length(length),
		.operand(operand),
		.insPc(insPc),
		.target(target),
		.targetValid(targetValid)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// outputs are stable mid-cycle
	always @(negedge clk)
	begin
		if (rstN && insValid)
			gotQ.push_back({opcode, mode, length, operand, insPc, target, targetValid});
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int nextGap();
		rngState = xorshift(rngState);
		return int'(rngState[1:0]); // 0 to 3 idle cycles
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
			$display("Simulation finished: FAIL");
			$fatal(1, "check failed");
		end
	endtask

	task automatic sendByte(input logic [7:0] b, input int gap);
		repeat (gap)
		begin
			@(posedge clk);
			byteValid <= 1'b0;
		end
		@(posedge clk);
		byteValid <= 1'b1;
		byteData <= b;
	endtask

	task automatic idle();
		@(posedge clk);
		byteValid <= 1'b0;
	endtask

	task automatic pulseRestart(input logic [15:0] pc);
		@(posedge clk);
		byteValid <= 1'b0;
		restart <= 1'b1;
		restartPc <= pc;
		@(posedge clk);
		restart <= 1'b0;
	endtask

	task automatic waitIns(input string name, input typepkg::Opcode expOp,
		input typepkg::Addressing expMode, input logic [1:0] expLen,
		input logic [15:0] expOperand, input logic [15:0] expPc,
		input logic expTv, input logic [15:0] expTarget);
		int waited;
		logic [61:0] rec;
		waited = 0;
		while (gotQ.size() == 0)
		begin
			if (waited == 20)
			begin
				$display("Timeout in %s: no instruction reported within 20 cycles", name);
				$display("Simulation finished: FAIL");
				$fatal(1, "timeout");
			end
			else
			begin
				@(posedge clk);
				waited++;
			end
		end
		rec = gotQ.pop_front();
		checkValue({name, ".opcode"}, 32'(expOp), 32'(rec[61:55]));
		checkValue({name, ".mode"}, 32'(expMode), 32'(rec[54:51]));
		checkValue({name, ".length"}, 32'(expLen), 32'(rec[50:49]));
		checkValue({name, ".operand"}, 32'(expOperand), 32'(rec[48:33]));
		checkValue({name, ".insPc"}, 32'(expPc), 32'(rec[32:17]));
		checkValue({name, ".target"}, 32'(expTarget), 32'(rec[16:1]));
		checkValue({name, ".targetValid"}, 32'(expTv), 32'(rec[0]));
	endtask

	// nothing further may come out
	task automatic confirmNoExtra(input string name);
		repeat (6) @(posedge clk);
		checkValue({name, ".extra"}, 32'd0, 32'(gotQ.size()));
	endtask

	task automatic resetNop();
		sendByte(8'hEA, 0);
		idle();
		waitIns("reset", typepkg::NOP, typepkg::Imp, 2'd1, 16'h0000, typepkg::resetPc,
			1'b0, 16'h0000);
		confirmNoExtra("reset");
	endtask

	task automatic mixedLengths(input string name, input bit useGaps);
		logic [7:0] stream [10] = '{8'hA9, 8'h42, 8'hA5, 8'h10, 8'h8D, 8'h34, 8'h12,
			8'hEA, 8'hB6, 8'h80};
		pulseRestart(16'h0300);
		foreach (stream[i])
			sendByte(stream[i], useGaps ? nextGap() : 0);
		idle();
		waitIns(name, typepkg::LDA, typepkg::Imm, 2'd2, 16'h0042, 16'h0300, 1'b0, 16'h0);
		waitIns(name, typepkg::LDA, typepkg::Zp, 2'd2, 16'h0010, 16'h0302, 1'b0, 16'h0);
		waitIns(name, typepkg::STA, typepkg::Abs, 2'd3, 16'h1234, 16'h0304, 1'b0, 16'h0);
		waitIns(name, typepkg::NOP, typepkg::Imp, 2'd1, 16'h0000, 16'h0307, 1'b0, 16'h0);
		waitIns(name, typepkg::LDX, typepkg::ZpY, 2'd2, 16'h0080, 16'h0308, 1'b0, 16'h0);
		confirmNoExtra(name);
	endtask

	task automatic relativeBranches();
		pulseRestart(16'hFFF0);
		sendByte(8'hD0, 0);
		sendByte(8'h10, 0);
		pulseRestart(16'h0004); // backward branch wraps below zero
		sendByte(8'hD0, 0);
		sendByte(8'hF0, 0);
		idle();
		waitIns("branch", typepkg::BNE, typepkg::Rel, 2'd2, 16'h0010, 16'hFFF0, 1'b1, 16'h0002);
		waitIns("branch", typepkg::BNE, typepkg::Rel, 2'd2, 16'h00F0, 16'h0004, 1'b1, 16'hFFF6);
		confirmNoExtra("branch");
	endtask

	task automatic absoluteJumps();
		logic [7:0] stream [12] = '{8'h4C, 8'h00, 8'h80, 8'h20, 8'h56, 8'h34,
			8'h6C, 8'h00, 8'h90, 8'hAD, 8'h78, 8'h56};
		pulseRestart(16'h0400);
		foreach (stream[i])
			sendByte(stream[i], 0);
		idle();
		waitIns("jump", typepkg::JMP, typepkg::Abs, 2'd3, 16'h8000, 16'h0400, 1'b1, 16'h8000);
		waitIns("jump", typepkg::JSR, typepkg::Abs, 2'd3, 16'h3456, 16'h0403, 1'b1, 16'h3456);
		waitIns("jump", typepkg::JMP, typepkg::Ind, 2'd3, 16'h9000, 16'h0406, 1'b0, 16'h0000);
		waitIns("jump", typepkg::LDA, typepkg::Abs, 2'd3, 16'h5678, 16'h0409, 1'b0, 16'h0000);
		confirmNoExtra("jump");
	endtask

	task automatic restartDiscard();
		pulseRestart(16'h0500);
		sendByte(8'hEA, 0);
		sendByte(8'h8D, 0); // STA abs cut short
		pulseRestart(16'h1234);
		sendByte(8'hA9, 0);
		sendByte(8'h77, 0);
		idle();
		waitIns("restart", typepkg::NOP, typepkg::Imp, 2'd1, 16'h0000, 16'h0500, 1'b0, 16'h0);
		waitIns("restart", typepkg::LDA, typepkg::Imm, 2'd2, 16'h0077, 16'h1234, 1'b0, 16'h0);
		confirmNoExtra("restart");
	endtask

	initial
	begin
		rstN = 1'b0;
		byteValid = 1'b0;
		byteData = 8'h00;
		restart = 1'b0;
		restartPc = 16'h0000;
		repeat (15)
		begin
			@(negedge clk);
			checkValue("reset.insValid", 32'd0, 32'(insValid));
			checkValue("reset.targetValid", 32'd0, 32'(targetValid));
		end
		@(posedge clk);
		rstN <= 1'b1;
		repeat (3)
		begin
			@(negedge clk);
			checkValue("reset.insValid", 32'd0, 32'(insValid));
			checkValue("reset.targetValid", 32'd0, 32'(targetValid));
		end
		resetNop();
		mixedLengths("mixed", 1'b0);
		relativeBranches();
		absoluteJumps();
		mixedLengths("gaps", 1'b1); // same results with idle cycles
		restartDiscard();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- src/predecodeTop.sv
`timescale 1ns/100ps

module predecodeTop (
	input logic clk,
	input logic rstN,
	input logic byteValid,
	input typepkg::dataLogic byteData,
	input logic restart,
	input logic [15:0] restartPc,
	output logic insValid,
	output typepkg::Opcode opcode,
	output typepkg::Addressing mode,
	output logic [1:0] length,
	output logic [15:0] operand,
	output logic [15:0] insPc,
	output logic [15:0] target,
	output logic targetValid
);

	logic asmValid; // stage 1 to stage 2
	typepkg::Opcode asmOpcode;
	typepkg::Addressing asmMode;
	logic [1:0] asmLength;
	logic [15:0] asmOperand;
	logic [15:0] asmPc;

	insAssemble assembler (
		.clk(clk),
		.rstN(rstN),
		.byteValid(byteValid),
		.byteData(byteData),
		.restart(restart),
		.restartPc(restartPc),
		.asmValid(asmValid),
		.asmOpcode(asmOpcode),
		.asmMode(asmMode),
		.asmLength(asmLength),
		.asmOperand(asmOperand),
		.asmPc(asmPc)
	);

	branchTarget targetStage (
		.clk(clk),
		.rstN(rstN),
		.asmValid(asmValid),
		.asmOpcode(asmOpcode),
		.asmMode(asmMode),
		.asmLength(asmLength),
		.asmOperand(asmOperand),
		.asmPc(asmPc),
		.insValid(insValid),
		.opcode(opcode),
		.mode(mode),
		.length(length),
		.operand(operand),
		.insPc(insPc),
		.target(target),
		.targetValid(targetValid)
	);

endmodule

//--- src/branchTarget.sv
`timescale 1ns/100ps

module branchTarget (
	input logic clk,
	input logic rstN,
	input logic asmValid,
	input typepkg::Opcode asmOpcode,
	input typepkg::Addressing asmMode,
	input logic [1:0] asmLength,
	input logic [15:0] asmOperand,
	input logic [15:0] asmPc,
	output logic insValid,
	output typepkg::Opcode opcode,
	output typepkg::Addressing mode,
	output logic [1:0] length,
	output logic [15:0] operand,
	output logic [15:0] insPc,
	output logic [15:0] target,
	output logic targetValid
);

	logic [15:0] nextPc;
	logic [15:0] relTarget;
	logic isRel;
	logic isJump;

	assign nextPc = asmPc + 16'd2; // branches are always two bytes
	assign relTarget = nextPc + {{8{asmOperand[7]}}, asmOperand[7:0]};
	assign isRel = asmMode == typepkg::Rel;
	assign isJump = (asmOpcode == typepkg::JMP || asmOpcode == typepkg::JSR)
		&& asmMode == typepkg::Abs; // JMP ind has no static target

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			insValid <= 1'b0;
			targetValid <= 1'b0;
		end
		else
		begin
			insValid <= asmValid;
			targetValid <= asmValid && (isRel || isJump);
		end
	end

	always_ff @(posedge clk)
	begin
		if (asmValid)
		begin
			opcode <= asmOpcode;
			mode <= asmMode;
			length <= asmLength;
			operand <= asmOperand;
			insPc <= asmPc;
			target <= isRel ? relTarget : (isJump ? asmOperand : 16'h0000);
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) targetValid |-> insValid)
		else $error("branchTarget: targetValid without insValid");

endmodule

//--- src/insAssemble.sv
`timescale 1ns/100ps

module insAssemble (
	input logic clk,
	input logic rstN,
	input logic byteValid,
	input typepkg::dataLogic byteData,
	input logic restart,
	input logic [15:0] restartPc,
	output logic asmValid,
	output typepkg::Opcode asmOpcode,
	output typepkg::Addressing asmMode,
	output logic [1:0] asmLength,
	output logic [15:0] asmOperand,
	output logic [15:0] asmPc
);

	typepkg::Opcode decOpcode;
	typepkg::Addressing decMode;
	logic [1:0] decLength;

	logic [15:0] pc; // address of the next byte
	logic collecting; // opcode seen, operand bytes pending
	logic [1:0] count; // bytes taken so far
	typepkg::Opcode workOpcode;
	typepkg::Addressing workMode;
	logic [1:0] workLength;
	logic [15:0] workPc;
	typepkg::dataLogic lowByte; // first operand byte

	logic accept;
	logic startByte;
	logic oneByte;
	logic lastByte;

	idec decoder (
		.ins(byteData),
		.opcode(decOpcode),
		.mode(decMode),
		.pcBytes(decLength)
	);

	assign accept = byteValid && !restart; // restart wins over a byte
	assign startByte = accept && !collecting;
	assign oneByte = startByte && decLength == 2'd1;
	assign lastByte = accept && collecting && (count + 2'd1 == workLength);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc <= typepkg::resetPc;
			collecting <= 1'b0;
			count <= 2'd0;
			asmValid <= 1'b0;
		end
		else
		begin
			asmValid <= oneByte || lastByte;
			if (restart)
			begin
				pc <= restartPc;
				collecting <= 1'b0; // drop partial instruction
				count <= 2'd0;
			end
			else if (accept)
			begin
				pc <= pc + 16'd1; // wraps at 16 bits
				if (startByte)
				begin
					collecting <= !oneByte;
					count <= 2'd1;
				end
				else if (lastByte)
				begin
					collecting <= 1'b0;
					count <= 2'd0;
				end
				else
					count <= count + 2'd1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (startByte)
		begin
			workOpcode <= decOpcode;
			workMode <= decMode;
			workLength <= decLength;
			workPc <= pc;
		end
		if (accept && collecting)
			lowByte <= byteData;
		if (oneByte)
		begin
			asmOpcode <= decOpcode;
			asmMode <= decMode;
			asmLength <= decLength;
			asmOperand <= 16'h0000;
			asmPc <= pc;
		end
		else if (lastByte)
		begin
			asmOpcode <= workOpcode;
			asmMode <= workMode;
			asmLength <= workLength;
			asmOperand <= (workLength == 2'd3) ? {byteData, lowByte} : {8'h00, byteData};
			asmPc <= workPc;
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		collecting |-> count < workLength)
		else $error("insAssemble: byte count reached stored length");

	// a multi-byte instruction needs at least two edges after the previous one
	assert property (@(posedge clk) disable iff (!rstN)
		asmValid |=> !asmValid || asmLength == 2'd1)
		else $error("insAssemble: back-to-back asmValid on a multi-byte instruction");

endmodule

//--- src/idec.sv
`timescale 1ns/100ps

module idec (
	input typepkg::dataLogic ins,
	output typepkg::Opcode opcode,
	output typepkg::Addressing mode,
	output logic [1:0] pcBytes
);

	assign opcode = typepkg::opTable[ins];
	assign mode = typepkg::modeTable[ins];

	// instruction length in bytes, opcode included
	always_comb
	begin
		pcBytes = 2'd0;
		case (mode)
			typepkg::Imp:
				pcBytes = 2'd1;
			typepkg::Imm, typepkg::IzX, typepkg::IzY,
			typepkg::Zp, typepkg::ZpX, typepkg::ZpY,
			typepkg::Rel:
				pcBytes = 2'd2; // one operand byte
			typepkg::Abs, typepkg::AbX, typepkg::AbY,
			typepkg::Ind:
				pcBytes = 2'd3; // 16-bit operand
			default:
				pcBytes = 2'd0; // not a table mode
		endcase
	end

	// every entry of the map must yield a usable length
	always_comb
	begin
		if (!$isunknown(ins))
			assert (pcBytes != 2'd0)
				else $error("idec: zero length for opcode byte %h", ins);
	end

endmodule

//--- src/typepkg.sv
package typepkg;

	typedef logic [7:0] dataLogic; // one program byte

	// order follows first appearance in the opcode map
	typedef enum logic [6:0]
	{
		BRK, ORA, KIL, SLO, NOP, ASL, PHP, ANC, BPL, CLC,
		JSR, AND, RLA, BIT, ROL, PLP, BMI, SEC, RTI, EOR,
		SRE, LSR, PHA, ALR, JMP, BVC, CLI, RTS, ADC, RRA,
		ROR, PLA, ARR, BVS, SEI, STA, SAX, STY, STX, DEY,
		TXA, XAA, BCC, AHX, TYA, TXS, TAS, SHY, SHX, LDY,
		LDA, LDX, LAX, TAY, TAX, BCS, CLV, TSX, LAS, CPY,
		CMP, DCP, DEC, INY, DEX, AXS, BNE, CLD, CPX, SBC,
		ISC, INC, INX, BEQ, SED
	} Opcode;

	typedef enum logic [3:0]
	{
		Imp, Imm, Ind, IzX, IzY, Zp, ZpX, ZpY, Abs, AbX, AbY, Rel
	} Addressing;

	localparam logic [15:0] resetPc = 16'h0200; // address of the byte after reset

	localparam Opcode opTable [256] = '{
		BRK, ORA, KIL, SLO, NOP, ORA, ASL, SLO, PHP, ORA, ASL, ANC, NOP, ORA, ASL, SLO, // 0x
		BPL, ORA, KIL, SLO, NOP, ORA, ASL, SLO, CLC, ORA, NOP, SLO, NOP, ORA, ASL, SLO, // 1x
		JSR, AND, KIL, RLA, BIT, AND, ROL, RLA, PLP, AND, ROL, ANC, BIT, AND, ROL, RLA, // 2x
		BMI, AND, KIL, RLA, NOP, AND, ROL, RLA, SEC, AND, NOP, RLA, NOP, AND, ROL, RLA, // 3x
		RTI, EOR, KIL, SRE, NOP, EOR, LSR, SRE, PHA, EOR, LSR, ALR, JMP, EOR, LSR, SRE, // 4x
		BVC, EOR, KIL, SRE, NOP, EOR, LSR, SRE, CLI, EOR, NOP, SRE, NOP, EOR, LSR, SRE, // 5x
		RTS, ADC, KIL, RRA, NOP, ADC, ROR, RRA, PLA, ADC, ROR, ARR, JMP, ADC, ROR, RRA, // 6x
		BVS, ADC, KIL, RRA, NOP, ADC, ROR, RRA, SEI, ADC, NOP, RRA, NOP, ADC, ROR, RRA, // 7x
		NOP, STA, NOP, SAX, STY, STA, STX, SAX, DEY, NOP, TXA, XAA, STY, STA, STX, SAX, // 8x
		BCC, STA, KIL, AHX, STY, STA, STX, SAX, TYA, STA, TXS, TAS, SHY, STA, SHX, AHX, // 9x
		LDY, LDA, LDX, LAX, LDY, LDA, LDX, LAX, TAY, LDA, TAX, LAX, LDY, LDA, LDX, LAX, // ax
		BCS, LDA, KIL, LAX, LDY, LDA, LDX, LAX, CLV, LDA, TSX, LAS, LDY, LDA, LDX, LAX, // bx
		CPY, CMP, NOP, DCP, CPY, CMP, DEC, DCP, INY, CMP, DEX, AXS, CPY, CMP, DEC, DCP, // cx
		BNE, CMP, KIL, DCP, NOP, CMP, DEC, DCP, CLD, CMP, NOP, DCP, NOP, CMP, DEC, DCP, // dx
		CPX, SBC, NOP, ISC, CPX, SBC, INC, ISC, INX, SBC, NOP, SBC, CPX, SBC, INC, ISC, // ex
		BEQ, SBC, KIL, ISC, NOP, SBC, INC, ISC, SED, SBC, NOP, ISC, NOP, SBC, INC, ISC  // fx
	};

	// KIL and other jam codes sit in the Imp slots
	localparam Addressing modeTable [256] = '{
		Imp, IzX, Imp, IzX, Zp,  Zp,  Zp,  Zp,  Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs, // 0x
		Rel, IzY, Imp, IzY, ZpX, ZpX, ZpX, ZpX, Imp, AbY, Imp, AbY, AbX, AbX, AbX, AbX, // 1x
		Abs, IzX, Imp, IzX, Zp,  Zp,  Zp,  Zp,  Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs, // 2x
		Rel, IzY, Imp, IzY, ZpX, ZpX, ZpX, ZpX, Imp, AbY, Imp, AbY, AbX, AbX, AbX, AbX, // 3x
		Imp, IzX, Imp, IzX, Zp,  Zp,  Zp,  Zp,  Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs, // 4x
		Rel, IzY, Imp, IzY, ZpX, ZpX, ZpX, ZpX, Imp, AbY, Imp, AbY, AbX, AbX, AbX, AbX, // 5x
		Imp, IzX, Imp, IzX, Zp,  Zp,  Zp,  Zp,  Imp, Imm, Imp, Imm, Ind, Abs, Abs, Abs, // 6x
		Rel, IzY, Imp, IzY, ZpX, ZpX, ZpX, ZpX, Imp, AbY, Imp, AbY, AbX, AbX, AbX, AbX, // 7x
		Imm, IzX, Imm, IzX, Zp,  Zp,  Zp,  Zp,  Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs, // 8x
		Rel, IzY, Imp, IzY, ZpX, ZpX, ZpY, ZpY, Imp, AbY, Imp, AbY, AbX, AbX, AbY, AbY, // 9x
		Imm, IzX, Imm, IzX, Zp,  Zp,  Zp,  Zp,  Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs, // ax
		Rel, IzY, Imp, IzY, ZpX, ZpX, ZpY, ZpY, Imp, AbY, Imp, AbY, AbX, AbX, AbY, AbY, // bx
		Imm, IzX, Imm, IzX, Zp,  Zp,  Zp,  Zp,  Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs, // cx
		Rel, IzY, Imp, IzY, ZpX, ZpX, ZpX, ZpX, Imp, AbY, Imp, AbY, AbX, AbX, AbX, AbX, // dx
		Imm, IzX, Imm, IzX, Zp,  Zp,  Zp,  Zp,  Imp, Imm, Imp, Imm, Abs, Abs, Abs, Abs, // ex
		Rel, IzY, Imp, IzY, ZpX, ZpX, ZpX, ZpX, Imp, AbY, Imp, AbY, AbX, AbX, AbX, AbX  // fx
	};

endpackage
